/* common/rob_pkg.sv */
`default_nettype none

package rob_pkg;

	localparam int XLEN      = 32;
	localparam int ROB_DEPTH = 8;
	localparam int TAG_W     = 3;
	// branch, arithmetic and load/store completion ports
	localparam int CPL_PORTS = 3;

	// rv32i major opcodes, encoded as in the ISA
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} opcode_e;

	typedef enum logic [1:0] {
		unit_br,
		unit_acu,
		unit_lsq,
		unit_none
	} unit_e;

	typedef struct packed {
		opcode_e          opcode;
		logic [XLEN-1:0]  pc;
		logic [4:0]       rd;
		logic             br_pred;
		logic [XLEN-1:0]  branch_pc;
	} instr_info_t;

	typedef struct packed {
		instr_info_t      info;
		logic [XLEN-1:0]  data;
		logic             done;
		logic             valid;
	} rob_entry_t;

	// head entry handed over to commit
	typedef struct packed {
		instr_info_t      info;
		logic [XLEN-1:0]  data;
	} retire_t;

endpackage

`default_nettype wire

/* common/cpl_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one execution result, written back into its rob entry
interface cpl_if;
	logic                       valid;
	logic [rob_pkg::TAG_W-1:0]  tag;
	logic [rob_pkg::XLEN-1:0]   data;
	// branch outcome, only meaningful on the branch port
	logic                       taken;

	modport source (
		output valid, tag, data, taken
	);

	modport sink (
		input valid, tag, data, taken
	);
endinterface

`default_nettype wire

/* src/dispatch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        issue_valid_i,
	input  logic                        stall_br_i,
	input  logic                        stall_acu_i,
	input  logic                        stall_lsq_i,
	input  logic                        full_i,
	input  logic                        retiring_i,
	input  logic                        flush_i,
	input  rob_pkg::instr_info_t        issue_info_i,
	input  logic [rob_pkg::TAG_W-1:0]   tail_tag_i,
	output logic                        issue_accept_o,
	output logic                        load_br_o,
	output logic                        load_acu_o,
	output logic                        load_lsq_o,
	output logic                        reg_write_o,
	output logic                        alloc_o,
	output rob_pkg::instr_info_t        alloc_info_o,
	output logic [rob_pkg::TAG_W-1:0]   issue_tag_o
);
	rob_pkg::unit_e unit;
	logic           unit_stall;
	logic           has_space;
	logic           accept;

	// lui goes to the lsq, the same as loads and stores
	always_comb begin
		case (issue_info_i.opcode)
			rob_pkg::op_br, rob_pkg::op_jal, rob_pkg::op_jalr:    unit = rob_pkg::unit_br;
			rob_pkg::op_lui, rob_pkg::op_load, rob_pkg::op_store: unit = rob_pkg::unit_lsq;
			rob_pkg::op_auipc, rob_pkg::op_imm, rob_pkg::op_reg:  unit = rob_pkg::unit_acu;
			default:                                              unit = rob_pkg::unit_none;
		endcase
	end

	always_comb begin
		case (unit)
			rob_pkg::unit_br:  unit_stall = stall_br_i;
			rob_pkg::unit_acu: unit_stall = stall_acu_i;
			rob_pkg::unit_lsq: unit_stall = stall_lsq_i;
			// illegal opcode never issues
			default:           unit_stall = 1'b1;
		endcase
	end

	// a full buffer still takes one if the head leaves this cycle
	assign has_space = !full_i || retiring_i;
	assign accept    = issue_valid_i && !flush_i && !unit_stall && has_space;

	assign issue_accept_o = accept;
	assign alloc_o        = accept;
	assign alloc_info_o   = issue_info_i;
	assign issue_tag_o    = tail_tag_i;

	assign load_br_o  = accept && (unit == rob_pkg::unit_br);
	assign load_acu_o = accept && (unit == rob_pkg::unit_acu);
	assign load_lsq_o = accept && (unit == rob_pkg::unit_lsq);

	assign reg_write_o = accept && (issue_info_i.opcode != rob_pkg::op_br) &&
		(issue_info_i.opcode != rob_pkg::op_store);

	a_one_load: assert property (@(posedge clk) disable iff (rst)
		$onehot0({load_br_o, load_acu_o, load_lsq_o}))
		else $error("more than one reservation station loaded");

endmodule

`default_nettype wire

/* rob/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        alloc_i,
	input  rob_pkg::instr_info_t        alloc_info_i,
	cpl_if.sink                         cpl_br,
	cpl_if.sink                         cpl_acu,
	cpl_if.sink                         cpl_lsq,
	input  logic                        commit_ready_i,
	output logic                        full_o,
	output logic                        retiring_o,
	output logic [rob_pkg::TAG_W-1:0]   tail_tag_o,
	output logic                        retire_valid_o,
	output rob_pkg::retire_t            retire_o,
	output logic                        flush_valid_o,
	output logic [rob_pkg::XLEN-1:0]    flush_pc_o
);
	rob_pkg::rob_entry_t mem [rob_pkg::ROB_DEPTH];

	logic [rob_pkg::TAG_W-1:0]      head;
	logic [rob_pkg::TAG_W-1:0]      tail;
	logic [rob_pkg::TAG_W:0]        count;
	// slots cut by a flush and not yet reused
	logic [rob_pkg::ROB_DEPTH-1:0]  killed;

	logic [rob_pkg::CPL_PORTS-1:0]  cpl_valid;
	logic [rob_pkg::TAG_W-1:0]      cpl_tag  [rob_pkg::CPL_PORTS];
	logic [rob_pkg::XLEN-1:0]       cpl_data [rob_pkg::CPL_PORTS];

	rob_pkg::rob_entry_t            br_ent;
	logic                           br_hit;
	logic                           mispredict;
	logic [rob_pkg::XLEN-1:0]       redirect_pc;
	logic [rob_pkg::TAG_W-1:0]      br_offset;
	logic [rob_pkg::TAG_W:0]        keep_count;
	logic [rob_pkg::ROB_DEPTH-1:0]  kill_mask;
	logic                           alloc_ok;

	assign cpl_valid   = {cpl_lsq.valid, cpl_acu.valid, cpl_br.valid};
	assign cpl_tag[0]  = cpl_br.tag;
	assign cpl_tag[1]  = cpl_acu.tag;
	assign cpl_tag[2]  = cpl_lsq.tag;
	assign cpl_data[0] = cpl_br.data;
	assign cpl_data[1] = cpl_acu.data;
	assign cpl_data[2] = cpl_lsq.data;

	assign full_o         = (count == (rob_pkg::TAG_W+1)'(rob_pkg::ROB_DEPTH));
	assign tail_tag_o     = tail;
	assign retiring_o     = commit_ready_i && mem[head].valid && mem[head].done;
	assign retire_valid_o = retiring_o;
	assign retire_o.info  = mem[head].info;
	assign retire_o.data  = mem[head].data;

	// branch result against its prediction
	assign br_ent = mem[cpl_br.tag];
	assign br_hit = cpl_br.valid && br_ent.valid;

	always_comb begin
		mispredict  = 1'b0;
		redirect_pc = br_ent.info.pc + 32'd4;
		case (br_ent.info.opcode)
			rob_pkg::op_br: begin
				mispredict = br_hit && (cpl_br.taken != br_ent.info.br_pred);
				if (cpl_br.taken)
					redirect_pc = br_ent.info.branch_pc;
			end
			// jalr: result data is the real target
			rob_pkg::op_jalr: begin
				mispredict  = br_hit && (cpl_br.data != br_ent.info.branch_pc);
				redirect_pc = cpl_br.data;
			end
			default: ;
		endcase
	end

	assign br_offset  = cpl_br.tag - head;
	assign keep_count = {1'b0, br_offset} + 1'b1;

	// everything after the branch up to the old tail
	always_comb begin
		logic [rob_pkg::TAG_W-1:0] off;
		for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
			off          = rob_pkg::TAG_W'(i) - head;
			kill_mask[i] = (off > br_offset) && ({1'b0, off} < count);
		end
	end

	// wrong-path instruction dispatched in the flush cycle is dropped
	assign alloc_ok = alloc_i && !mispredict;

	always_ff @(posedge clk) begin
		if (rst) begin
			head          <= '0;
			tail          <= '0;
			count         <= '0;
			killed        <= '0;
			flush_valid_o <= 1'b0;
			for (int i = 0; i < rob_pkg::ROB_DEPTH; i++)
				mem[i].valid <= 1'b0;
		end else begin
			flush_valid_o <= mispredict;
			if (mispredict)
				flush_pc_o <= redirect_pc;

			for (int p = 0; p < rob_pkg::CPL_PORTS; p++) begin
				if (cpl_valid[p] && mem[cpl_tag[p]].valid) begin
					mem[cpl_tag[p]].done <= 1'b1;
					mem[cpl_tag[p]].data <= cpl_data[p];
				end
			end

			if (retiring_o) begin
				mem[head].valid <= 1'b0;
				head            <= head + 1'b1;
			end

			if (mispredict) begin
				for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
					if (kill_mask[i]) begin
						mem[i].valid <= 1'b0;
						killed[i]    <= 1'b1;
					end
				end
				tail  <= cpl_br.tag + 1'b1;
				count <= keep_count - {{rob_pkg::TAG_W{1'b0}}, retiring_o};
			end else begin
				case ({alloc_ok, retiring_o})
					2'b10:   count <= count + 1'b1;
					2'b01:   count <= count - 1'b1;
					default: count <= count;
				endcase
				if (alloc_ok) begin
					mem[tail].info  <= alloc_info_i;
					mem[tail].data  <= '0;
					mem[tail].done  <= 1'b0;
					mem[tail].valid <= 1'b1;
					killed[tail]    <= 1'b0;
					tail            <= tail + 1'b1;
				end
			end
		end
	end

	a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
		alloc_i |-> (!full_o || retiring_o))
		else $error("allocation into a full reorder buffer");

	// a late result may still arrive for a flushed slot
	for (genvar p = 0; p < rob_pkg::CPL_PORTS; p++) begin : g_cpl_chk
		a_cpl_tag: assert property (@(posedge clk) disable iff (rst)
			cpl_valid[p] |-> (mem[cpl_tag[p]].valid || killed[cpl_tag[p]]))
			else $error("completion for unoccupied tag %0d", cpl_tag[p]);
	end

endmodule

`default_nettype wire

/* src/commit_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_stage (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        retire_valid_i,
	input  rob_pkg::retire_t            retire_i,
	output logic                        ready_o,
	output logic                        wb_valid_o,
	output logic [4:0]                  wb_rd_o,
	output logic [rob_pkg::XLEN-1:0]    wb_data_o,
	output logic                        bru_update_o,
	output logic                        bru_taken_o,
	output logic [rob_pkg::XLEN-1:0]    bru_pc_o
);
	logic                       writes_rd;
	logic                       is_branch;
	logic [rob_pkg::XLEN-1:0]   wb_value;

	assign is_branch = (retire_i.info.opcode == rob_pkg::op_br);
	assign writes_rd = !is_branch && (retire_i.info.opcode != rob_pkg::op_store) &&
		(retire_i.info.rd != 5'd0);

	// jumps write the link address
	always_comb begin
		case (retire_i.info.opcode)
			rob_pkg::op_jal, rob_pkg::op_jalr: wb_value = retire_i.info.pc + 32'd4;
			default:                           wb_value = retire_i.data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ready_o      <= 1'b0;
			wb_valid_o   <= 1'b0;
			bru_update_o <= 1'b0;
		end else begin
			// takes one entry every cycle once out of reset
			ready_o      <= 1'b1;
			wb_valid_o   <= retire_valid_i && writes_rd;
			bru_update_o <= retire_valid_i && is_branch;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd_o   <= retire_i.info.rd;
		wb_data_o <= wb_value;
		// branch result data holds the outcome in bit 0
		bru_taken_o <= retire_i.data[0];
		bru_pc_o    <= retire_i.info.pc;
	end

endmodule

`default_nettype wire

/* src/ooo_commit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_commit_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        issue_valid_i,
	input  logic [6:0]                  issue_opcode_i,
	input  logic [rob_pkg::XLEN-1:0]    issue_pc_i,
	input  logic [4:0]                  issue_rd_i,
	input  logic                        issue_br_pred_i,
	input  logic [rob_pkg::XLEN-1:0]    issue_branch_pc_i,
	input  logic                        stall_br_i,
	input  logic                        stall_acu_i,
	input  logic                        stall_lsq_i,
	input  logic                        cpl_br_valid_i,
	input  logic [rob_pkg::TAG_W-1:0]   cpl_br_tag_i,
	input  logic [rob_pkg::XLEN-1:0]    cpl_br_data_i,
	input  logic                        cpl_acu_valid_i,
	input  logic [rob_pkg::TAG_W-1:0]   cpl_acu_tag_i,
	input  logic [rob_pkg::XLEN-1:0]    cpl_acu_data_i,
	input  logic                        cpl_lsq_valid_i,
	input  logic [rob_pkg::TAG_W-1:0]   cpl_lsq_tag_i,
	input  logic [rob_pkg::XLEN-1:0]    cpl_lsq_data_i,
	output logic                        issue_accept_o,
	output logic [rob_pkg::TAG_W-1:0]   issue_tag_o,
	output logic                        load_br_o,
	output logic                        load_acu_o,
	output logic                        load_lsq_o,
	output logic                        reg_write_o,
	output logic                        wb_valid_o,
	output logic [4:0]                  wb_rd_o,
	output logic [rob_pkg::XLEN-1:0]    wb_data_o,
	output logic                        bru_update_o,
	output logic                        bru_taken_o,
	output logic [rob_pkg::XLEN-1:0]    bru_pc_o,
	output logic                        flush_valid_o,
	output logic [rob_pkg::XLEN-1:0]    flush_pc_o
);
	rob_pkg::instr_info_t       issue_info;
	rob_pkg::instr_info_t       alloc_info;
	rob_pkg::retire_t           retire;
	logic                       alloc;
	logic                       full;
	logic                       retiring;
	logic                       retire_valid;
	logic                       commit_ready;
	logic [rob_pkg::TAG_W-1:0]  tail_tag;

	cpl_if cpl_br ();
	cpl_if cpl_acu ();
	cpl_if cpl_lsq ();

	assign issue_info.opcode    = rob_pkg::opcode_e'(issue_opcode_i);
	assign issue_info.pc        = issue_pc_i;
	assign issue_info.rd        = issue_rd_i;
	assign issue_info.br_pred   = issue_br_pred_i;
	assign issue_info.branch_pc = issue_branch_pc_i;

	assign cpl_br.valid  = cpl_br_valid_i;
	assign cpl_br.tag    = cpl_br_tag_i;
	assign cpl_br.data   = cpl_br_data_i;
	assign cpl_br.taken  = cpl_br_data_i[0];
	assign cpl_acu.valid = cpl_acu_valid_i;
	assign cpl_acu.tag   = cpl_acu_tag_i;
	assign cpl_acu.data  = cpl_acu_data_i;
	assign cpl_acu.taken = 1'b0;
	assign cpl_lsq.valid = cpl_lsq_valid_i;
	assign cpl_lsq.tag   = cpl_lsq_tag_i;
	assign cpl_lsq.data  = cpl_lsq_data_i;
	assign cpl_lsq.taken = 1'b0;

	dispatch_stage u_dispatch_stage (
		.clk            (clk),
		.rst            (rst),
		.issue_valid_i  (issue_valid_i),
		.stall_br_i     (stall_br_i),
		.stall_acu_i    (stall_acu_i),
		.stall_lsq_i    (stall_lsq_i),
		.full_i         (full),
		.retiring_i     (retiring),
		.flush_i        (flush_valid_o),
		.issue_info_i   (issue_info),
		.tail_tag_i     (tail_tag),
		.issue_accept_o (issue_accept_o),
		.load_br_o      (load_br_o),
		.load_acu_o     (load_acu_o),
		.load_lsq_o     (load_lsq_o),
		.reg_write_o    (reg_write_o),
		.alloc_o        (alloc),
		.alloc_info_o   (alloc_info),
		.issue_tag_o    (issue_tag_o)
	);

	reorder_buffer u_reorder_buffer (
		.clk            (clk),
		.rst            (rst),
		.alloc_i        (alloc),
		.alloc_info_i   (alloc_info),
		.cpl_br         (cpl_br.sink),
		.cpl_acu        (cpl_acu.sink),
		.cpl_lsq        (cpl_lsq.sink),
		.commit_ready_i (commit_ready),
		.full_o         (full),
		.retiring_o     (retiring),
		.tail_tag_o     (tail_tag),
		.retire_valid_o (retire_valid),
		.retire_o       (retire),
		.flush_valid_o  (flush_valid_o),
		.flush_pc_o     (flush_pc_o)
	);

	commit_stage u_commit_stage (
		.clk            (clk),
		.rst            (rst),
		.retire_valid_i (retire_valid),
		.retire_i       (retire),
		.ready_o        (commit_ready),
		.wb_valid_o     (wb_valid_o),
		.wb_rd_o        (wb_rd_o),
		.wb_data_o      (wb_data_o),
		.bru_update_o   (bru_update_o),
		.bru_taken_o    (bru_taken_o),
		.bru_pc_o       (bru_pc_o)
	);

endmodule

`default_nettype wire

/* sim/ooo_commit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_commit_tb;
	localparam int WAIT_LIMIT = 64;

	logic        clk = 1'b0;
	logic        rst;
	logic        issue_valid_i;
	logic [6:0]  issue_opcode_i;
	logic [31:0] issue_pc_i;
	logic [4:0]  issue_rd_i;
	logic        issue_br_pred_i;
	logic [31:0] issue_branch_pc_i;
	logic        stall_br_i;
	logic        stall_acu_i;
	logic        stall_lsq_i;
	logic        cpl_br_valid_i;
	logic [2:0]  cpl_br_tag_i;
	logic [31:0] cpl_br_data_i;
	logic        cpl_acu_valid_i;
	logic [2:0]  cpl_acu_tag_i;
	logic [31:0] cpl_acu_data_i;
	logic        cpl_lsq_valid_i;
	logic [2:0]  cpl_lsq_tag_i;
	logic [31:0] cpl_lsq_data_i;
	logic        issue_accept_o;
	logic [2:0]  issue_tag_o;
	logic        load_br_o;
	logic        load_acu_o;
	logic        load_lsq_o;
	logic        reg_write_o;
	logic        wb_valid_o;
	logic [4:0]  wb_rd_o;
	logic [31:0] wb_data_o;
	logic        bru_update_o;
	logic        bru_taken_o;
	logic [31:0] bru_pc_o;
	logic        flush_valid_o;
	logic [31:0] flush_pc_o;

	// one line of the cases file
	logic [31:0] iv, op, pc, rd, bp, bpc, st;
	logic [31:0] bv, bt, bd, av, at, ad, lv, lt, ld;
	logic [31:0] acc, tag, ew, wdat, eb, btk, ef, fpc;

	// expected results in program order: {rd, data}, {taken, pc}, target
	logic [36:0] wb_exp [$];
	logic [32:0] bru_exp [$];
	logic [31:0] flush_exp [$];

	int errors;
	int checks;

	ooo_commit_top u_ooo_commit_top (
		.clk               (clk),
		.rst               (rst),
		.issue_valid_i     (issue_valid_i),
		.issue_opcode_i    (issue_opcode_i),
		.issue_pc_i        (issue_pc_i),
		.issue_rd_i        (issue_rd_i),
		.issue_br_pred_i   (issue_br_pred_i),
		.issue_branch_pc_i (issue_branch_pc_i),
		.stall_br_i        (stall_br_i),
		.stall_acu_i       (stall_acu_i),
		.stall_lsq_i       (stall_lsq_i),
		.cpl_br_valid_i    (cpl_br_valid_i),
		.cpl_br_tag_i      (cpl_br_tag_i),
		.cpl_br_data_i     (cpl_br_data_i),
		.cpl_acu_valid_i   (cpl_acu_valid_i),
		.cpl_acu_tag_i     (cpl_acu_tag_i),
		.cpl_acu_data_i    (cpl_acu_data_i),
		.cpl_lsq_valid_i   (cpl_lsq_valid_i),
		.cpl_lsq_tag_i     (cpl_lsq_tag_i),
		.cpl_lsq_data_i    (cpl_lsq_data_i),
		.issue_accept_o    (issue_accept_o),
		.issue_tag_o       (issue_tag_o),
		.load_br_o         (load_br_o),
		.load_acu_o        (load_acu_o),
		.load_lsq_o        (load_lsq_o),
		.reg_write_o       (reg_write_o),
		.wb_valid_o        (wb_valid_o),
		.wb_rd_o           (wb_rd_o),
		.wb_data_o         (wb_data_o),
		.bru_update_o      (bru_update_o),
		.bru_taken_o       (bru_taken_o),
		.bru_pc_o          (bru_pc_o),
		.flush_valid_o     (flush_valid_o),
		.flush_pc_o        (flush_pc_o)
	);

	always #20 clk = ~clk;

	// reservation station for each opcode class, as {br, acu, lsq}
	function automatic logic [2:0] station_for(input logic [6:0] opcode);
		case (opcode)
			7'h63, 7'h6f, 7'h67: return 3'b100;
			7'h13, 7'h33, 7'h17: return 3'b010;
			7'h03, 7'h23, 7'h37: return 3'b001;
			default:             return 3'b000;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("ERROR %0t %s: expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_writeback();
		logic [36:0] exp;
		assert (wb_exp.size() != 0)
		else begin
			errors++;
			$display("writeback to x%0d at %0t when nothing should retire", wb_rd_o, $time);
		end
		if (wb_exp.size() != 0) begin
			exp = wb_exp.pop_front();
			check_value("wb_rd_o", 32'(wb_rd_o), 32'(exp[36:32]));
			check_value("wb_data_o", wb_data_o, exp[31:0]);
		end
	endtask

	task automatic check_branch_update();
		logic [32:0] exp;
		assert (bru_exp.size() != 0)
		else begin
			errors++;
			$display("branch update at %0t with no branch left to retire", $time);
		end
		if (bru_exp.size() != 0) begin
			exp = bru_exp.pop_front();
			check_value("bru_taken_o", 32'(bru_taken_o), 32'(exp[32]));
			check_value("bru_pc_o", bru_pc_o, exp[31:0]);
		end
	endtask

	task automatic check_flush();
		assert (flush_exp.size() != 0)
		else begin
			errors++;
			$display("flush at %0t although no branch was mispredicted", $time);
		end
		if (flush_exp.size() != 0)
			check_value("flush_pc_o", flush_pc_o, flush_exp.pop_front());
	endtask

	// registered outputs are stable in the low half of the clock
	always @(negedge clk) begin
		if (!rst) begin
			if (wb_valid_o)
				check_writeback();
			if (bru_update_o)
				check_branch_update();
			if (flush_valid_o)
				check_flush();
		end
	end

	task automatic drive_cycle();
		logic [2:0] exp_load;
		@(posedge clk);
		issue_valid_i     <= iv[0];
		issue_opcode_i    <= op[6:0];
		issue_pc_i        <= pc;
		issue_rd_i        <= rd[4:0];
		issue_br_pred_i   <= bp[0];
		issue_branch_pc_i <= bpc;
		stall_br_i        <= st[2];
		stall_acu_i       <= st[1];
		stall_lsq_i       <= st[0];
		cpl_br_valid_i    <= bv[0];
		cpl_br_tag_i      <= bt[2:0];
		cpl_br_data_i     <= bd;
		cpl_acu_valid_i   <= av[0];
		cpl_acu_tag_i     <= at[2:0];
		cpl_acu_data_i    <= ad;
		cpl_lsq_valid_i   <= lv[0];
		cpl_lsq_tag_i     <= lt[2:0];
		cpl_lsq_data_i    <= ld;
		if (ew[0])
			wb_exp.push_back({rd[4:0], wdat});
		if (eb[0])
			bru_exp.push_back({btk[0], pc});
		if (ef[0])
			flush_exp.push_back(fpc);
		@(negedge clk);
		check_value("issue_accept_o", 32'(issue_accept_o), acc);
		if (acc[0])
			check_value("issue_tag_o", 32'(issue_tag_o), tag);
		// a refused instruction loads no station
		exp_load = acc[0] ? station_for(op[6:0]) : 3'b000;
		check_value("load_br_o", 32'(load_br_o), 32'(exp_load[2]));
		check_value("load_acu_o", 32'(load_acu_o), 32'(exp_load[1]));
		check_value("load_lsq_o", 32'(load_lsq_o), 32'(exp_load[0]));
		// branches and stores leave the register file alone
		check_value("reg_write_o", 32'(reg_write_o),
			32'(acc[0] && (op[6:0] != 7'h63) && (op[6:0] != 7'h23)));
	endtask

	initial begin
		int    fd;
		int    n;
		int    waited;
		string line;
		rst               = 1'b1;
		issue_valid_i     = 1'b0;
		issue_opcode_i    = '0;
		issue_pc_i        = '0;
		issue_rd_i        = '0;
		issue_br_pred_i   = 1'b0;
		issue_branch_pc_i = '0;
		stall_br_i        = 1'b0;
		stall_acu_i       = 1'b0;
		stall_lsq_i       = 1'b0;
		cpl_br_valid_i    = 1'b0;
		cpl_br_tag_i      = '0;
		cpl_br_data_i     = '0;
		cpl_acu_valid_i   = 1'b0;
		cpl_acu_tag_i     = '0;
		cpl_acu_data_i    = '0;
		cpl_lsq_valid_i   = 1'b0;
		cpl_lsq_tag_i     = '0;
		cpl_lsq_data_i    = '0;
		errors            = 0;
		checks            = 0;

		fd = $fopen("sim/ooo_commit_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the cases file sim/ooo_commit_cases.txt");
		end

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		while (fd != 0 && !$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				iv, op, pc, rd, bp, bpc, st, bv, bt, bd, av, at, ad, lv, lt, ld,
				acc, tag, ew, wdat, eb, btk, ef, fpc);
			if (n != 24) begin
				errors++;
				$display("malformed line in the cases file: %s", line);
				continue;
			end
			drive_cycle();
		end
		if (fd != 0)
			$fclose(fd);

		// idle inputs, then let the buffer drain
		iv = 0;
		bv = 0;
		av = 0;
		lv = 0;
		st = 0;
		ew = 0;
		eb = 0;
		ef = 0;
		acc = 0;
		drive_cycle();
		waited = 0;
		while ((wb_exp.size() != 0 || bru_exp.size() != 0 || flush_exp.size() != 0) &&
			waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		assert (waited < WAIT_LIMIT)
		else begin
			errors++;
			$display("timed out with %0d writebacks, %0d branch updates, %0d flushes missing",
				wb_exp.size(), bru_exp.size(), flush_exp.size());
		end
		// a few quiet cycles catch stray pulses
		repeat (4) @(posedge clk);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/ooo_commit_cases.txt */
# iv op pc rd bp bpc st  br:v tag data  acu:v tag data  lsq:v tag data  acc tag  wb:e data  bru:e taken  flush:e pc
# st = stall bits br,acu,lsq; wb rd and bru pc come from the issue columns of the same line
1 13 100 01 0 000 0 0 0 0000 0 0 000 0 0 000 1 0 1 011 0 0 0 000
1 33 104 02 0 000 0 0 0 0000 0 0 000 0 0 000 1 1 1 022 0 0 0 000
1 03 108 03 0 000 0 0 0 0000 0 0 000 0 0 000 1 2 1 033 0 0 0 000
1 23 10c 00 0 000 0 0 0 0000 0 0 000 1 2 033 1 3 0 000 0 0 0 000
1 63 110 00 1 200 0 0 0 0000 1 1 022 0 0 000 1 4 0 000 1 1 0 000
1 6f 120 05 0 000 0 0 0 0000 1 0 011 1 3 000 1 5 1 124 0 0 0 000
1 67 130 06 1 300 0 1 4 0001 0 0 000 0 0 000 1 6 1 134 0 0 0 000
0 00 000 00 0 000 0 1 5 dead 0 0 000 0 0 000 0 0 0 000 0 0 0 000
0 00 000 00 0 000 0 1 6 0300 0 0 000 0 0 000 0 0 0 000 0 0 0 000
1 63 140 00 0 180 0 0 0 0000 0 0 000 0 0 000 1 7 0 000 1 1 0 000
1 13 144 07 0 000 0 0 0 0000 0 0 000 0 0 000 1 0 0 000 0 0 0 000
1 13 148 08 0 000 0 0 0 0000 0 0 000 0 0 000 1 1 0 000 0 0 0 000
0 00 000 00 0 000 0 1 7 0001 0 0 000 0 0 000 0 0 0 000 0 0 1 180
1 13 180 09 0 000 0 0 0 0000 0 0 000 0 0 000 0 0 0 000 0 0 0 000
1 13 180 09 0 000 0 0 0 0000 1 1 088 0 0 000 1 0 1 099 0 0 0 000
0 00 000 00 0 000 0 0 0 0000 1 0 099 0 0 000 0 0 0 000 0 0 0 000
1 13 200 0a 0 000 2 0 0 0000 0 0 000 0 0 000 0 0 0 000 0 0 0 000
1 03 204 0b 0 000 2 0 0 0000 0 0 000 0 0 000 1 1 1 0a1 0 0 0 000
1 13 208 0c 0 000 4 0 0 0000 0 0 000 0 0 000 1 2 1 0a2 0 0 0 000
1 6f 20c 0d 0 000 4 0 0 0000 0 0 000 0 0 000 0 0 0 000 0 0 0 000
1 6f 20c 0d 0 000 0 0 0 0000 0 0 000 0 0 000 1 3 1 210 0 0 0 000
1 37 210 0e 0 000 0 0 0 0000 0 0 000 0 0 000 1 4 1 0a4 0 0 0 000
1 17 214 0f 0 000 0 0 0 0000 0 0 000 0 0 000 1 5 1 0a5 0 0 0 000
1 33 218 10 0 000 0 0 0 0000 0 0 000 0 0 000 1 6 1 0a6 0 0 0 000
1 23 21c 00 0 000 0 0 0 0000 0 0 000 0 0 000 1 7 0 000 0 0 0 000
1 13 220 11 0 000 0 0 0 0000 0 0 000 0 0 000 1 0 1 0a8 0 0 0 000
1 13 224 12 0 000 0 0 0 0000 0 0 000 0 0 000 0 0 0 000 0 0 0 000
1 13 224 12 0 000 0 0 0 0000 0 0 000 1 1 0a1 0 0 0 000 0 0 0 000
1 13 224 12 0 000 0 0 0 0000 0 0 000 0 0 000 1 1 1 0a9 0 0 0 000
0 00 000 00 0 000 0 1 3 1234 1 2 0a2 1 4 0a4 0 0 0 000 0 0 0 000
0 00 000 00 0 000 0 0 0 0000 1 5 0a5 1 7 000 0 0 0 000 0 0 0 000
0 00 000 00 0 000 0 0 0 0000 1 6 0a6 0 0 000 0 0 0 000 0 0 0 000
0 00 000 00 0 000 0 0 0 0000 1 0 0a8 0 0 000 0 0 0 000 0 0 0 000
0 00 000 00 0 000 0 0 0 0000 1 1 0a9 0 0 000 0 0 0 000 0 0 0 000

/* vlog.f */
common/rob_pkg.sv
common/cpl_if.sv
src/dispatch_stage.sv
rob/reorder_buffer.sv
src/commit_stage.sv
src/ooo_commit_top.sv
sim/ooo_commit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and pass only if the pass line appears
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module ooo_commit_tb \
	-o ooo_commit_sim \
	&& ./obj_dir/ooo_commit_sim | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
